//--- source/dftConfigPkg.sv
// Analyzer sizes and derived widths
// Scalar typedefs for samples, phases, sums and magnitudes
// Sequencer broadcast, trig pair and per-octave magnitude structs
package dftConfigPkg;

    localparam int octaveCount = 3;                        // Octaves in the analyzer
    localparam int binCount    = 4;                        // Bins per octave
    localparam int inWidth     = 12;                       // External sample width
    localparam int sampleWidth = inWidth + octaveCount - 1; // Room for two pairwise sums
    localparam int trigWidth   = 12;                       // Signed table values
    localparam int phaseWidth  = 6;                        // 64 table entries
    localparam int topWindow   = 32;                       // Octave 0 window, halves per octave
    localparam int sumWidth    = sampleWidth + trigWidth + $clog2(topWindow);
    localparam int magWidth    = sumWidth;

    typedef logic [$clog2(octaveCount)-1:0] octaveIdxT;
    typedef logic [$clog2(binCount)-1:0]    binIdxT;
    typedef logic [phaseWidth-1:0]          phaseT;
    typedef logic signed [sampleWidth-1:0]  sampleT;
    typedef logic signed [trigWidth-1:0]    trigT;
    typedef logic signed [sumWidth-1:0]     sumT;         // Running sine or cosine sum
    typedef logic [magWidth-1:0]            magT;

    // Sequencer broadcast, one step of the frame walk
    typedef struct packed {
        octaveIdxT octave;     // Octave being worked on
        binIdxT    bin;        // Bin being worked on
        logic      addPass;    // High for add pass, low for subtract pass
        logic      calcActive; // High during both passes
    } opCtrlT;

    // Sine and cosine read at the same phase
    typedef struct packed {
        trigT sinVal;
        trigT cosVal;
    } trigPairT;

    typedef magT [binCount-1:0] binMagsT; // One octave's magnitudes

endpackage

//--- source/trigTablePkg.sv
// Quarter-symmetric sine table scaled to 2047
// Per-bin phase advance per sample
// Start phases of the oldest-sample counters per octave and bin
package trigTablePkg;

    localparam int tableSize     = 2 ** dftConfigPkg::phaseWidth;
    localparam int quarterPeriod = tableSize / 4;   // Cosine offset into the sine table

    // Entry i is round(2047 * sin(2*pi*i/64))
    localparam dftConfigPkg::trigT sineTable [tableSize] = '{
           0,   201,   399,   594,   783,   965,  1137,  1299,
        1447,  1582,  1702,  1805,  1891,  1959,  2008,  2037,
        2047,  2037,  2008,  1959,  1891,  1805,  1702,  1582,
        1447,  1299,  1137,   965,   783,   594,   399,   201,
           0,  -201,  -399,  -594,  -783,  -965, -1137, -1299,
       -1447, -1582, -1702, -1805, -1891, -1959, -2008, -2037,
       -2047, -2037, -2008, -1959, -1891, -1805, -1702, -1582,
       -1447, -1299, -1137,  -965,  -783,  -594,  -399,  -201
    };

    // Table steps per sample, one per bin
    localparam dftConfigPkg::phaseT binStep [dftConfigPkg::binCount] = '{
        6'd1, 6'd2, 6'd3, 6'd5
    };

    // Minus window length times step, mod 64
    // Windows are 32, 16 and 8 samples
    localparam dftConfigPkg::phaseT
        windowPhaseOffset [dftConfigPkg::octaveCount][dftConfigPkg::binCount] = '{
        '{6'd32, 6'd0,  6'd32, 6'd32},  // Octave 0
        '{6'd48, 6'd32, 6'd16, 6'd48},  // Octave 1
        '{6'd56, 6'd48, 6'd40, 6'd24}   // Octave 2
    };

endpackage

//--- source/operationManager.sv
// Frame sequencer FSM
// Accepts one sample, strobes the write, then walks every octave
// through a subtract pass and an add pass over all bins
`timescale 1ns/100ps

module operationManager (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sampleValid,
    output logic                 ready,
    output logic                 writeStrobe,
    output logic                 frameDone,
    output dftConfigPkg::opCtrlT opCtrl
);
    import dftConfigPkg::*;

    typedef enum logic [2:0] {stWait, stWrite, stSub, stAdd, stDone} opStateT;

    opStateT   state, stateNext;
    octaveIdxT octaveCnt;    // Octave being walked
    binIdxT    binCnt;       // Bin inside the current pass
    logic      lastBin, lastOctave;

    assign lastBin    = (binCnt == binIdxT'(binCount - 1));
    assign lastOctave = (octaveCnt == octaveIdxT'(octaveCount - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= stWait;
        else
            state <= stateNext;
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            stWait:  if (sampleValid) stateNext = stWrite;   // Handshake on ready
            stWrite: stateNext = stSub;
            stSub:   if (lastBin) stateNext = stAdd;
            stAdd:   if (lastBin) stateNext = lastOctave ? stDone : stSub;
            stDone:  stateNext = stWait;
            default: stateNext = stWait;
        endcase
    end

    // Counters restart with every write so each frame walks from octave 0
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            octaveCnt <= '0;
            binCnt    <= '0;
        end
        else if (state == stWrite)
        begin
            octaveCnt <= '0;
            binCnt    <= '0;
        end
        else if (state == stSub || state == stAdd)
        begin
            binCnt <= lastBin ? '0 : binCnt + 1'b1;              // Wrap per pass
            if (state == stAdd && lastBin && !lastOctave)
                octaveCnt <= octaveCnt + 1'b1;                   // Next octave after add pass
        end
    end

    always_comb
    begin
        ready              = (state == stWait);
        writeStrobe        = (state == stWrite);
        frameDone          = (state == stDone);
        opCtrl.octave      = octaveCnt;
        opCtrl.bin         = binCnt;
        opCtrl.addPass     = (state == stAdd);
        opCtrl.calcActive  = (state == stSub) || (state == stAdd);
    end

endmodule

//--- source/octaveSelector.sv
// Decimation scheduler
// Octave i is enabled in frames whose index is a multiple of 2**i
`timescale 1ns/100ps

module octaveSelector (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 frameDone,
    output logic [dftConfigPkg::octaveCount-1:0] octaveEnable
);
    import dftConfigPkg::*;

    logic [octaveCount-2:0] frameCnt, framePrev;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frameCnt  <= '0;
            framePrev <= '1;   // Every bit counts as fallen, so frame 0 enables all
        end
        else if (frameDone)
        begin
            framePrev <= frameCnt;
            frameCnt  <= frameCnt + 1'b1;
        end
    end

    assign octaveEnable[0]               = 1'b1;                   // Top octave takes every sample
    assign octaveEnable[octaveCount-1:1] = framePrev & ~frameCnt;  // Falling counter bits
endmodule

//--- source/trigTable.sv
// Shared sine and cosine lookup
// Only the octave being walked gets its phase served
`timescale 1ns/100ps

module trigTable (
    input  dftConfigPkg::opCtrlT                                    opCtrl,
    input  dftConfigPkg::phaseT [dftConfigPkg::octaveCount-1:0]     phaseReq,
    output dftConfigPkg::trigPairT                                  trig
);
    import dftConfigPkg::*;
    import trigTablePkg::*;

    phaseT phaseSel;   // Requested phase of the active octave
    phaseT cosIdx;     // Quarter turn ahead, wraps at 64

    always_comb
    begin
        phaseSel    = phaseReq[opCtrl.octave];
        cosIdx      = phaseSel + phaseT'(quarterPeriod);
        trig.sinVal = sineTable[phaseSel];
        trig.cosVal = sineTable[cosIdx];
    end

endmodule

//--- source/phaseCounters.sv
// Per-bin table phases for one octave
// Newest phase serves the add pass, oldest phase the subtract pass
// Each advances by the bin's step when its pass runs
`timescale 1ns/100ps

module phaseCounters #(
    parameter int octaveIndex = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dftConfigPkg::opCtrlT opCtrl,
    input  logic                 active,
    output dftConfigPkg::phaseT  phase
);
    import dftConfigPkg::*;
    import trigTablePkg::*;

    phaseT newestPhase [binCount];   // Phase of the next sample to enter
    phaseT oldestPhase [binCount];   // Phase of the next sample to leave

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int b = 0; b < binCount; b++)
            begin
                newestPhase[b] <= '0;
                oldestPhase[b] <= windowPhaseOffset[octaveIndex][b]; // One window behind
            end
        end
        else if (active)
        begin
            if (opCtrl.addPass)
                newestPhase[opCtrl.bin] <= newestPhase[opCtrl.bin] + binStep[opCtrl.bin];
            else
                oldestPhase[opCtrl.bin] <= oldestPhase[opCtrl.bin] + binStep[opCtrl.bin];
        end
    end

    // Current value is used this cycle, the advanced one next frame
    assign phase = opCtrl.addPass ? newestPhase[opCtrl.bin] : oldestPhase[opCtrl.bin];

endmodule

//--- source/sampleWindow.sv
// Circular sample store for one octave
// Gives the newest and previous sample and the one leaving the window
`timescale 1ns/100ps

module sampleWindow #(
    parameter int windowLength = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 takeSample,
    input  dftConfigPkg::sampleT sampleIn,
    output dftConfigPkg::sampleT newest,
    output dftConfigPkg::sampleT previous,
    output dftConfigPkg::sampleT leaving
);
    import dftConfigPkg::*;

    localparam int ptrWidth = $clog2(windowLength);

    sampleT               windowMem [windowLength];
    logic [ptrWidth-1:0]  writePtr;   // Slot holding the oldest sample
    logic                 filled;     // Window has wrapped at least once

    // Storage itself, read and overwritten at the same slot
    always_ff @(posedge clk)
    begin
        if (takeSample)
            windowMem[writePtr] <= sampleIn;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            writePtr <= '0;
            filled   <= 1'b0;
            newest   <= '0;
            previous <= '0;
            leaving  <= '0;
        end
        else if (takeSample)
        begin
            newest   <= sampleIn;
            previous <= newest;
            leaving  <= filled ? windowMem[writePtr] : '0;  // Empty slots read as zero
            if (writePtr == ptrWidth'(windowLength - 1))
            begin
                writePtr <= '0;
                filled   <= 1'b1;
            end
            else
            begin
                writePtr <= writePtr + 1'b1;
            end
        end
    end

endmodule

//--- source/octaveChannel.sv
// One octave of the sliding DFT
// Sample window, phase counters, running sine/cosine sums per bin
// and the approximate magnitude of each bin
`timescale 1ns/100ps

module octaveChannel #(
    parameter int octaveIndex = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  dftConfigPkg::opCtrlT   opCtrl,
    input  logic                   octaveOn,
    input  logic                   takeSample,
    input  dftConfigPkg::sampleT   sampleIn,
    input  dftConfigPkg::trigPairT trig,
    output dftConfigPkg::phaseT    phaseReq,
    output dftConfigPkg::sampleT   decimatedOut,
    output dftConfigPkg::binMagsT  mags
);
    import dftConfigPkg::*;

    logic   calcEn;                    // This octave's turn and enabled this frame
    sampleT newest, previous, leaving;
    sampleT operand;                   // Leaving sample on subtract, newest on add
    logic signed [sampleWidth+trigWidth-1:0] sinProd, cosProd;
    sumT    sinSum [binCount];
    sumT    cosSum [binCount];
    sumT    absSin, absCos;
    magT    bigVal, smallVal, magNext;

    assign calcEn = octaveOn && opCtrl.calcActive && (opCtrl.octave == octaveIdxT'(octaveIndex));

    phaseCounters #(.octaveIndex(octaveIndex)) u_phaseCounters (
        .clk    (clk),
        .rst    (rst),
        .opCtrl (opCtrl),
        .active (calcEn),
        .phase  (phaseReq)
    );

    sampleWindow #(.windowLength(topWindow >> octaveIndex)) u_sampleWindow (
        .clk        (clk),
        .rst        (rst),
        .takeSample (takeSample),
        .sampleIn   (sampleIn),
        .newest     (newest),
        .previous   (previous),
        .leaving    (leaving)
    );

    assign decimatedOut = newest + previous;  // Pairwise sum feeds the octave below

    always_comb
    begin
        operand  = opCtrl.addPass ? newest : leaving;
        sinProd  = trig.sinVal * operand;
        cosProd  = trig.cosVal * operand;
        absSin   = sinSum[opCtrl.bin][sumWidth-1] ? -sinSum[opCtrl.bin] : sinSum[opCtrl.bin];
        absCos   = cosSum[opCtrl.bin][sumWidth-1] ? -cosSum[opCtrl.bin] : cosSum[opCtrl.bin];
        bigVal   = (absSin > absCos) ? magT'(absSin) : magT'(absCos);
        smallVal = (absSin > absCos) ? magT'(absCos) : magT'(absSin);
        magNext  = bigVal + (smallVal >> 1);   // Larger plus half the smaller
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sinSum <= '{default: '0};
            cosSum <= '{default: '0};
            mags   <= '0;
        end
        else if (calcEn && !opCtrl.addPass)
        begin
            sinSum[opCtrl.bin] <= sinSum[opCtrl.bin] - sinProd;  // Drop the leaving sample
            cosSum[opCtrl.bin] <= cosSum[opCtrl.bin] - cosProd;
        end
        else if (calcEn)
        begin
            sinSum[opCtrl.bin] <= sinSum[opCtrl.bin] + sinProd;  // Add the newest sample
            cosSum[opCtrl.bin] <= cosSum[opCtrl.bin] + cosProd;
            mags[opCtrl.bin]   <= magNext;                       // Sums before this add
        end
    end

endmodule

//--- source/dftTop.sv
// Multi-octave sliding DFT top level
// Sequencer, decimation scheduler, shared trig table and octave chain
`timescale 1ns/100ps

module dftTop (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic signed [dftConfigPkg::inWidth-1:0]               sampleIn,
    input  logic                                                  sampleValid,
    output logic                                                  ready,
    output logic                                                  frameDone,
    output dftConfigPkg::binMagsT [dftConfigPkg::octaveCount-1:0] magnitudes
);
    import dftConfigPkg::*;

    opCtrlT                   opCtrl;
    logic                     writeStrobe;
    logic [octaveCount-1:0]   octaveEnable;
    phaseT [octaveCount-1:0]  phaseReq;       // One table request per octave
    trigPairT                 trig;
    sampleT                   chainSample [octaveCount+1];  // Input of each octave

    assign chainSample[0] = sampleT'(sampleIn);  // Sign-extend to the internal width

    operationManager u_operationManager (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .ready       (ready),
        .writeStrobe (writeStrobe),
        .frameDone   (frameDone),
        .opCtrl      (opCtrl)
    );

    octaveSelector u_octaveSelector (
        .clk          (clk),
        .rst          (rst),
        .frameDone    (frameDone),
        .octaveEnable (octaveEnable)
    );

    trigTable u_trigTable (
        .opCtrl   (opCtrl),
        .phaseReq (phaseReq),
        .trig     (trig)
    );

    for (genvar o = 0; o < octaveCount; o++)
    begin : octaveGen
        octaveChannel #(.octaveIndex(o)) u_octaveChannel (
            .clk          (clk),
            .rst          (rst),
            .opCtrl       (opCtrl),
            .octaveOn     (octaveEnable[o]),
            .takeSample   (octaveEnable[o] & writeStrobe),
            .sampleIn     (chainSample[o]),
            .trig         (trig),
            .phaseReq     (phaseReq[o]),
            .decimatedOut (chainSample[o+1]),  // Pairwise sums into the next octave
            .mags         (magnitudes[o])
        );
    end

endmodule

//--- test/dft_properties.sv
// Concurrent assertions on the frame sequencer
// Handshake exclusion, frame latency, bin walk, one frame per sample
`timescale 1ns/100ps

module dftProperties (
    input logic                 clk,
    input logic                 rst,
    input logic                 sampleValid,
    input logic                 ready,
    input logic                 writeStrobe,
    input logic                 frameDone,
    input dftConfigPkg::opCtrlT opCtrl
);
    import dftConfigPkg::*;

    int framesOwed;   // Accepted samples whose frame is still running

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            framesOwed <= 0;
        else
            framesOwed <= framesOwed + int'(ready && sampleValid) - int'(frameDone);
    end

    noOverlap: assert property (@(posedge clk) disable iff (rst) !(ready && writeStrobe))
        else $error("ready and writeStrobe are high in the same cycle");

    frameLatency: assert property (@(posedge clk) disable iff (rst) writeStrobe |-> ##25 frameDone)
        else $error("frameDone missing 25 cycles after writeStrobe");

    frameOrigin: assert property (@(posedge clk) disable iff (rst)
        frameDone |-> $past(writeStrobe, 25))
        else $error("frameDone without writeStrobe 25 cycles earlier");

    // Bin starts at zero and steps by one through 0 to binCount-1 in every pass
    binWalk: assert property (@(posedge clk) disable iff (rst)
        opCtrl.calcActive |->
            opCtrl.bin == ($past(opCtrl.calcActive) ? binIdxT'($past(opCtrl.bin) + 1)
                                                    : binIdxT'(0)))
        else $error("bin index out of sequence");

    oneFramePerSample: assert property (@(posedge clk) disable iff (rst)
        frameDone |-> framesOwed == 1)
        else $error("frameDone count does not match accepted samples");

endmodule

//--- test/dftChecker.sv
// Reference model of the multi-octave sliding DFT
// Watches acceptance and frameDone, predicts every bin magnitude
// and keeps per-test and total error counts
`timescale 1ns/100ps

module dftChecker (
    input logic                                                  clk,
    input logic                                                  rst,
    input logic signed [dftConfigPkg::inWidth-1:0]               sampleIn,
    input logic                                                  sampleValid,
    input logic                                                  ready,
    input logic                                                  frameDone,
    input dftConfigPkg::binMagsT [dftConfigPkg::octaveCount-1:0] magnitudes
);
    import dftConfigPkg::*;

    localparam int latency = 26;                        // Acceptance to frameDone

    int     sineRef [64];
    int     stepRef [binCount] = '{1, 2, 3, 5};          // Table steps per bin
    longint sinAcc [octaveCount][binCount] = '{default: 0};
    longint cosAcc [octaveCount][binCount] = '{default: 0};
    longint magRef [octaveCount][binCount] = '{default: 0};
    int     history [octaveCount][topWindow];           // Slot n mod window per octave
    int     taken [octaveCount] = '{default: 0};        // Samples each octave has taken
    int     newestRef [octaveCount] = '{default: 0};
    int     prevRef [octaveCount] = '{default: 0};
    int     frameIdx = 0, pendingSample = 0, cycles = 0;
    bit     pending = 1'b0;
    string  testName = "";
    int     expectedFrames, testFrames, testErrors;
    int     errorCount = 0, testsRun = 0, testsFailed = 0;

    initial
    begin
        for (int i = 0; i < 64; i++)
            sineRef[i] = int'(2047.0 * $sin(2.0 * 3.14159265358979 * i / 64.0));  // Rounded
    end

    function automatic longint approxMag(longint s, longint c);
        longint a, b;
        a = (s < 0) ? -s : s;
        b = (c < 0) ? -c : c;
        return (a > b) ? a + (b >>> 1) : b + (a >>> 1);   // Larger plus half the smaller
    endfunction

    task automatic compareValue(string what, longint expected, longint actual);
        if (expected != actual)
        begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d",
                     testName, what, expected, actual);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic reportProblem(string msg);
        $display("Error in test %s: %s", testName, msg);
        testErrors++;
        errorCount++;
    endtask

    task automatic updateOctave(int k, int value);
        int win, n, leave, pOld, pNew;
        win   = topWindow >> k;
        n     = taken[k];
        leave = (n >= win) ? history[k][n % win] : 0;       // Zero until the window filled
        history[k][n % win] = value;
        for (int b = 0; b < binCount; b++)
        begin
            pOld = ((n - win) * stepRef[b]) & 63;           // Phase the leaving sample had
            pNew = (n * stepRef[b]) & 63;
            sinAcc[k][b] -= longint'(leave) * sineRef[pOld];
            cosAcc[k][b] -= longint'(leave) * sineRef[(pOld + 16) & 63];
            magRef[k][b] = approxMag(sinAcc[k][b], cosAcc[k][b]);   // Before the add
            sinAcc[k][b] += longint'(value) * sineRef[pNew];
            cosAcc[k][b] += longint'(value) * sineRef[(pNew + 16) & 63];
        end
        prevRef[k]   = newestRef[k];
        newestRef[k] = value;
        taken[k]++;
    endtask

    task automatic processFrame();
        int octIn [octaveCount];
        octIn[0] = pendingSample;
        for (int k = 1; k < octaveCount; k++)
            octIn[k] = newestRef[k-1] + prevRef[k-1];        // Pair stored before this frame
        for (int k = 0; k < octaveCount; k++)
            if (frameIdx % (1 << k) == 0)
                updateOctave(k, octIn[k]);
        for (int k = 0; k < octaveCount; k++)
            for (int b = 0; b < binCount; b++)
                compareValue($sformatf("frame %0d octave %0d bin %0d magnitude", frameIdx, k, b),
                             magRef[k][b], longint'(magnitudes[k][b]));
        frameIdx++;
    endtask

    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (pending)
                cycles++;
            if (frameDone)
            begin
                testFrames++;
                if (!pending)
                    reportProblem("frameDone pulsed without an accepted sample");
                else
                begin
                    compareValue("frameDone latency", latency, cycles);
                    processFrame();
                end
                pending = 1'b0;
            end
            if (ready && sampleValid)
            begin
                if (pending)
                    reportProblem("a second sample was accepted inside one frame");
                pending       = 1'b1;
                pendingSample = int'(sampleIn);              // Sign-extended
                cycles        = 0;
            end
        end
    end

    task automatic startTest(string name, int frames);
        testName       = name;
        expectedFrames = frames;
        testFrames     = 0;
        testErrors     = 0;
    endtask

    task automatic checkReset();
        compareValue("ready after reset", 1, longint'(ready));
        compareValue("frameDone after reset", 0, longint'(frameDone));
        for (int k = 0; k < octaveCount; k++)
            for (int b = 0; b < binCount; b++)
                compareValue($sformatf("octave %0d bin %0d reset magnitude", k, b),
                             0, longint'(magnitudes[k][b]));
    endtask

    task automatic endTest();
        compareValue("frame count", expectedFrames, testFrames);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("Test %-12s %s  frames %0d  errors %0d", testName,
                 (testErrors == 0) ? "passed" : "failed", testFrames, testErrors);
    endtask

    task automatic reportTotals();
        $display("Totals: %0d tests, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
    endtask

endmodule

//--- test/dftTb.sv
// Testbench top for the sliding DFT analyzer
// Clock and reset, stimulus table, drive loop and final verdict
`timescale 1ns/100ps

module dftTb;
    import dftConfigPkg::*;

    typedef enum {patImpulse, patConstant, patAlternating, patRandom} patternT;

    typedef struct {
        string   name;
        patternT kind;
        int      count;       // Samples sent
        int      amplitude;   // Peak value of the pattern
        bit      holdValid;   // sampleValid stays high across frames
        int      frames;      // Expected frameDone pulses
    } stimRowT;

    localparam int rowCount  = 5;
    localparam int waitLimit = 64;   // Cycles allowed for any single wait

    stimRowT stimTable [rowCount] = '{
        '{"impulse",     patImpulse,     36, 2047, 1'b0, 36},  // Runs past the top window
        '{"constant",    patConstant,    24, 1500, 1'b0, 24},
        '{"alternating", patAlternating, 24, 1800, 1'b0, 24},
        '{"random",      patRandom,      48, 2047, 1'b0, 48},  // Wraps every window
        '{"random held", patRandom,      16, 2047, 1'b1, 16}
    };

    logic                      clk, rst, sampleValid, ready, frameDone;
    logic signed [inWidth-1:0] sampleIn;
    binMagsT [octaveCount-1:0] magnitudes;
    int                        seed;
    bit                        timedOut;

    dftTop u_dftTop (.*);

    dftChecker u_dftChecker (.*);

    bind operationManager dftProperties u_dftProperties (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    function automatic int patternValue(patternT kind, int amplitude, int idx);
        case (kind)
            patImpulse:     return (idx == 0) ? amplitude : 0;
            patConstant:    return amplitude;
            patAlternating: return idx[0] ? -amplitude : amplitude;
            default:        return $random(seed) % (amplitude + 1);
        endcase
    endfunction

    // Starts on a falling edge and ends one falling edge after frameDone
    task automatic sendSample(input int value, input bit holdValid, input string name);
        int waitCnt;
        sampleIn    = inWidth'(value);
        sampleValid = 1'b1;
        waitCnt     = 0;
        while (!ready && waitCnt < waitLimit)
        begin
            @(negedge clk);
            waitCnt++;
        end
        if (!ready)
        begin
            $display("Timeout in test %s: ready never rose", name);
            timedOut = 1'b1;
            return;
        end
        @(negedge clk);                  // Accepted on the rising edge before
        if (!holdValid)
            sampleValid = 1'b0;
        waitCnt = 0;
        while (!frameDone && waitCnt < waitLimit)
        begin
            @(negedge clk);
            waitCnt++;
        end
        if (!frameDone)
        begin
            $display("Timeout in test %s: frameDone never came", name);
            timedOut = 1'b1;
        end
        else
        begin
            @(negedge clk);              // Checker took the frame on the rising edge before
        end
    endtask

    initial
    begin
        seed        = 87;
        timedOut    = 1'b0;
        rst         = 1'b1;
        sampleValid = 1'b0;
        sampleIn    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        u_dftChecker.startTest("reset", 0);
        u_dftChecker.checkReset();
        u_dftChecker.endTest();
        for (int r = 0; r < rowCount && !timedOut; r++)
        begin
            u_dftChecker.startTest(stimTable[r].name, stimTable[r].frames);
            for (int i = 0; i < stimTable[r].count && !timedOut; i++)
                sendSample(patternValue(stimTable[r].kind, stimTable[r].amplitude, i),
                           stimTable[r].holdValid, stimTable[r].name);
            sampleValid = 1'b0;          // Dropped ahead of the next rising edge
            u_dftChecker.endTest();
        end
        u_dftChecker.reportTotals();
        if (!timedOut && u_dftChecker.errorCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- project.f
source/dftConfigPkg.sv
source/trigTablePkg.sv
source/operationManager.sv
source/octaveSelector.sv
source/trigTable.sv
source/phaseCounters.sv
source/sampleWindow.sv
source/octaveChannel.sv
source/dftTop.sv
test/dft_properties.sv
test/dftChecker.sv
test/dftTb.sv

//--- Bender.yml
package:
  name: octave_sdft

sources:
  - files:
      - source/dftConfigPkg.sv
      - source/trigTablePkg.sv
      - source/operationManager.sv
      - source/octaveSelector.sv
      - source/trigTable.sv
      - source/phaseCounters.sv
      - source/sampleWindow.sv
      - source/octaveChannel.sv
      - source/dftTop.sv
  - target: test
    files:
      - test/dft_properties.sv
      - test/dftChecker.sv
      - test/dftTb.sv
